/* verilog.f */
common/bubble_prof_pkg.sv
common/sb_update_if.sv
classifier/long_op_scoreboard.sv
classifier/exe_bubble_classifier.sv
verilog/bubble_counter_bank.sv
verilog/axil_prof_regs.sv
verilog/bubble_profiler_top.sv
bench/bubble_profiler_tb.sv

/* bench/profiler_golden.txt */
# C if_pc id_pc exe_pc ctrl(stall icmiss icpipe br jalr dep byp fence rreq) rs1 rs2 rd
#   use(rs1 rs2 rd) set_v set_rd set_kind clr_v clr_rd exp_type exp_pc
# R addr exp_data exp_resp   W addr data
C 1000 0ffc 0ff8 000000000 0 0 0 000 0 0 0 0 0 0 0000
C 2000 2004 2008 000100000 0 0 0 000 0 0 0 0 0 1 2008
C 2010 2010 200c 000000000 0 0 0 000 0 0 0 0 0 1 2008
C 3000 3008 300c 000010000 0 0 0 000 0 0 0 0 0 2 300c
C 3010 3010 3010 000000000 0 0 0 000 0 0 0 0 0 2 300c
C 4000 3ffc 3ff8 010000000 0 0 0 000 0 0 0 0 0 0 0000
C 4004 4000 3ffc 001000000 0 0 0 000 0 0 0 0 0 0 0000
C 4008 4004 4000 000000000 0 0 0 000 0 0 0 0 0 3 4000
C 5000 4ffc 4ff8 000000000 0 0 0 000 1 5 0 0 0 0 0000
C 5004 5004 5000 000001000 5 0 0 100 0 0 0 0 0 4 5004
C 5008 5008 5004 000001000 5 0 0 100 0 0 0 1 5 4 5008
C 500c 500c 5008 000001000 5 0 0 100 0 0 0 0 0 0 0000
C 6000 5ffc 5ff8 000000000 0 0 0 000 1 6 1 0 0 0 0000
C 6004 6000 5ffc 000000000 0 0 0 000 1 7 2 0 0 0 0000
C 6008 6004 6000 000001000 7 6 0 110 0 0 0 0 0 5 6004
C 7000 7000 6ffc 000000111 0 0 0 000 0 0 0 0 0 7 7000
C 7004 7004 7000 000000011 0 0 0 000 0 0 0 0 0 8 7004
C 7008 7008 7004 000000001 0 0 0 000 0 0 0 0 0 9 7008
C 8000 7ffc 8000 100100000 0 0 0 000 0 0 0 0 0 9 7008
C 8008 8000 8004 000100100 0 0 0 000 0 0 0 0 0 1 8004
C 9004 9000 8ffc 000000100 0 0 0 000 0 0 0 0 0 1 8004
R 00 00000007 0
R 04 00000004 0
R 08 00000002 0
R 0c 00000001 0
R 10 00000002 0
R 14 00000001 0
R 18 00000000 0
R 1c 00000001 0
R 20 00000001 0
R 24 00000001 0
R 80 00000000 2
W 40 00000001
R 04 00000000 0
R 00 00000000 0

/* bench/bubble_profiler_tb.sv */
module bubble_profiler_tb
  import bubble_prof_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  logic       clk_i;
  logic       reset_i;
  pc_t        if_pc_i;
  pc_t        id_pc_i;
  pc_t        exe_pc_i;
  logic       stall_all_i;
  logic       icache_miss_i;
  logic       icache_miss_in_pipe_i;
  logic       branch_mispredict_i;
  logic       jalr_mispredict_i;
  logic       stall_depend_long_op_i;
  logic       stall_bypass_i;
  logic       stall_fence_i;
  logic       stall_remote_req_i;
  reg_id_t    id_rs1_i;
  reg_id_t    id_rs2_i;
  reg_id_t    id_rd_i;
  logic       id_read_rs1_i;
  logic       id_read_rs2_i;
  logic       id_write_rd_i;
  logic       sb_set_valid_i;
  reg_id_t    sb_set_rd_i;
  long_op_e   sb_set_kind_i;
  logic       sb_clr_valid_i;
  reg_id_t    sb_clr_rd_i;
  axil_addr_t araddr_i;
  logic       arvalid_i;
  logic       arready_o;
  axil_data_t rdata_o;
  logic [1:0] rresp_o;
  logic       rvalid_o;
  logic       rready_i;
  axil_addr_t awaddr_i;
  logic       awvalid_i;
  logic       awready_o;
  axil_data_t wdata_i;
  logic       wvalid_i;
  logic       wready_o;
  logic [1:0] bresp_o;
  logic       bvalid_o;
  logic       bready_i;
  bubble_e    exe_bubble_type_o;
  pc_t        exe_bubble_pc_o;

  int          fd;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [31:0] rand_state;
  logic        pending; // Expected EXE result still to be checked
  logic [3:0]  exp_type_q;
  pc_t         exp_pc_q;

  bubble_profiler_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Core stalled, nothing issued or written back
  task automatic idle_core();
    if_pc_i  <= '0;
    id_pc_i  <= '0;
    exe_pc_i <= '0;
    {stall_all_i, icache_miss_i, icache_miss_in_pipe_i, branch_mispredict_i,
     jalr_mispredict_i, stall_depend_long_op_i, stall_bypass_i, stall_fence_i,
     stall_remote_req_i} <= 9'b1_0000_0000;
    id_rs1_i <= '0;
    id_rs2_i <= '0;
    id_rd_i  <= '0;
    {id_read_rs1_i, id_read_rs2_i, id_write_rd_i} <= 3'b000;
    sb_set_valid_i <= 1'b0;
    sb_set_rd_i    <= '0;
    sb_set_kind_i  <= dram_load;
    sb_clr_valid_i <= 1'b0;
    sb_clr_rd_i    <= '0;
  endtask

  task automatic check_pending();
    if (pending) begin
      check_value("exe_bubble_type_o", 32'(exe_bubble_type_o), 32'(exp_type_q));
      check_value("exe_bubble_pc_o", exe_bubble_pc_o, exp_pc_q);
      pending = 1'b0;
    end
  endtask

  // Last cycle line gets its edge, then the core idles
  task automatic flush_cycles();
    if (pending) begin
      idle_core();
      @(negedge clk_i);
      check_pending();
      @(posedge clk_i);
    end
  endtask

  task automatic axi_read(input axil_addr_t addr, input axil_data_t exp_data,
                          input logic [1:0] exp_resp);
    int         delay;
    axil_data_t got_data;
    logic [1:0] got_resp;
    delay     = int'(next_rand() >> 30); // 0 to 3 cycles
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!arready_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    repeat (delay) @(posedge clk_i);
    rready_i <= 1'b1;
    @(negedge clk_i);
    while (!rvalid_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    got_data = rdata_o;
    got_resp = rresp_o;
    @(posedge clk_i);
    rready_i <= 1'b0;
    check_value("rdata_o", got_data, exp_data);
    check_value("rresp_o", 32'(got_resp), 32'(exp_resp));
  endtask

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
    logic [1:0] got_resp;
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wvalid_i  <= 1'b1;
    bready_i  <= 1'b1;
    @(negedge clk_i);
    while (!awready_o || !wready_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    @(negedge clk_i);
    while (!bvalid_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    got_resp = bresp_o;
    @(posedge clk_i);
    bready_i <= 1'b0;
    check_value("bresp_o", 32'(got_resp), 32'd0); // OKAY
  endtask

  initial begin
    logic [63:0]      cmd;
    logic [8*128-1:0] line_buf;
    int               code;
    int               num_lines;
    pc_t              f_if_pc;
    pc_t              f_id_pc;
    pc_t              f_exe_pc;
    logic [8:0]       f_ctrl;
    reg_id_t          f_rs1;
    reg_id_t          f_rs2;
    reg_id_t          f_rd;
    logic [2:0]       f_use;
    logic             f_set_v;
    reg_id_t          f_set_rd;
    logic [1:0]       f_set_kind;
    logic             f_clr_v;
    reg_id_t          f_clr_rd;
    logic [3:0]       f_type;
    pc_t              f_pc;
    axil_addr_t       f_addr;
    axil_data_t       f_data;
    logic [1:0]       f_resp;
    reset_i    <= 1'b1;
    idle_core();
    araddr_i   <= '0;
    arvalid_i  <= 1'b0;
    rready_i   <= 1'b0;
    awaddr_i   <= '0;
    awvalid_i  <= 1'b0;
    wdata_i    <= '0;
    wvalid_i   <= 1'b0;
    bready_i   <= 1'b0;
    rand_state = 32'hd952_d03a;
    pending    = 1'b0;
    num_lines  = 0;
    fd = $fopen("bench/profiler_golden.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the golden file bench/profiler_golden.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line_buf, fd) != 0) begin
        num_lines++;
      end
    end
    $fclose(fd);
    cycle_limit = 20 * num_lines;
    fd = $fopen("bench/profiler_golden.txt", "r");
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    code = $fscanf(fd, " %s", cmd);
    while (code == 1) begin
      if (cmd == "#") begin
        code = $fgets(line_buf, fd);
      end else if (cmd == "C") begin
        code = $fscanf(fd, "%h %h %h %b %d %d %d %b %d %d %d %d %d %d %h",
                       f_if_pc, f_id_pc, f_exe_pc, f_ctrl, f_rs1, f_rs2, f_rd, f_use,
                       f_set_v, f_set_rd, f_set_kind, f_clr_v, f_clr_rd, f_type, f_pc);
        if (code != 15) begin
          abort_run("Golden file has a cycle line with missing fields");
        end
        if_pc_i  <= f_if_pc;
        id_pc_i  <= f_id_pc;
        exe_pc_i <= f_exe_pc;
        {stall_all_i, icache_miss_i, icache_miss_in_pipe_i, branch_mispredict_i,
         jalr_mispredict_i, stall_depend_long_op_i, stall_bypass_i, stall_fence_i,
         stall_remote_req_i} <= f_ctrl;
        id_rs1_i <= f_rs1;
        id_rs2_i <= f_rs2;
        id_rd_i  <= f_rd;
        {id_read_rs1_i, id_read_rs2_i, id_write_rd_i} <= f_use;
        sb_set_valid_i <= f_set_v;
        sb_set_rd_i    <= f_set_rd;
        sb_set_kind_i  <= long_op_e'(f_set_kind);
        sb_clr_valid_i <= f_clr_v;
        sb_clr_rd_i    <= f_clr_rd;
        @(negedge clk_i);
        check_pending(); // Result of the previous line
        pending    = 1'b1;
        exp_type_q = f_type;
        exp_pc_q   = f_pc;
        @(posedge clk_i);
      end else if (cmd == "R") begin
        code = $fscanf(fd, "%h %h %d", f_addr, f_data, f_resp);
        if (code != 3) begin
          abort_run("Golden file has a read line with missing fields");
        end
        flush_cycles();
        axi_read(f_addr, f_data, f_resp);
      end else if (cmd == "W") begin
        code = $fscanf(fd, "%h %h", f_addr, f_data);
        if (code != 2) begin
          abort_run("Golden file has a write line with missing fields");
        end
        flush_cycles();
        axi_write(f_addr, f_data);
      end else begin
        abort_run("Golden file has a line with an unknown command");
      end
      code = $fscanf(fd, " %s", cmd);
    end
    $fclose(fd);
    flush_cycles();
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog/bubble_profiler_top.sv */
module bubble_profiler_top
  import bubble_prof_pkg::*;
  (
  input logic clk_i
  ,input logic reset_i

  ,input pc_t     if_pc_i
  ,input pc_t     id_pc_i
  ,input pc_t     exe_pc_i
  ,input logic    stall_all_i
  ,input logic    icache_miss_i
  ,input logic    icache_miss_in_pipe_i
  ,input logic    branch_mispredict_i
  ,input logic    jalr_mispredict_i
  ,input logic    stall_depend_long_op_i
  ,input logic    stall_bypass_i
  ,input logic    stall_fence_i
  ,input logic    stall_remote_req_i
  ,input reg_id_t id_rs1_i
  ,input reg_id_t id_rs2_i
  ,input reg_id_t id_rd_i
  ,input logic    id_read_rs1_i
  ,input logic    id_read_rs2_i
  ,input logic    id_write_rd_i

  ,input logic     sb_set_valid_i
  ,input reg_id_t  sb_set_rd_i
  ,input long_op_e sb_set_kind_i
  ,input logic     sb_clr_valid_i
  ,input reg_id_t  sb_clr_rd_i

  ,input  axil_addr_t araddr_i
  ,input  logic       arvalid_i
  ,output logic       arready_o
  ,output axil_data_t rdata_o
  ,output logic [1:0] rresp_o
  ,output logic       rvalid_o
  ,input  logic       rready_i
  ,input  axil_addr_t awaddr_i
  ,input  logic       awvalid_i
  ,output logic       awready_o
  ,input  axil_data_t wdata_i
  ,input  logic       wvalid_i
  ,output logic       wready_o
  ,output logic [1:0] bresp_o
  ,output logic       bvalid_o
  ,input  logic       bready_i

  ,output bubble_e exe_bubble_type_o
  ,output pc_t     exe_bubble_pc_o
  );

  logic [int_regs_lp-1:0]    dram_pend;
  logic [int_regs_lp-1:0]    remote_pend;
  logic [int_regs_lp-1:0]    idiv_pend;
  logic                      bubble_valid;
  logic [cause_width_lp-1:0] rd_idx;
  count_t                    rd_count;
  logic                      clear_all;

  sb_update_if sb_upd ();

  assign sb_upd.set_valid = sb_set_valid_i;
  assign sb_upd.set_rd    = sb_set_rd_i;
  assign sb_upd.set_kind  = sb_set_kind_i;
  assign sb_upd.clr_valid = sb_clr_valid_i;
  assign sb_upd.clr_rd    = sb_clr_rd_i;

  long_op_scoreboard sb0 (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.upd(sb_upd.sink)
    ,.dram_pend_o(dram_pend)
    ,.remote_pend_o(remote_pend)
    ,.idiv_pend_o(idiv_pend)
  );

  exe_bubble_classifier cls0 (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.if_pc_i(if_pc_i)
    ,.id_pc_i(id_pc_i)
    ,.exe_pc_i(exe_pc_i)
    ,.stall_all_i(stall_all_i)
    ,.icache_miss_i(icache_miss_i)
    ,.icache_miss_in_pipe_i(icache_miss_in_pipe_i)
    ,.branch_mispredict_i(branch_mispredict_i)
    ,.jalr_mispredict_i(jalr_mispredict_i)
    ,.stall_depend_long_op_i(stall_depend_long_op_i)
    ,.stall_bypass_i(stall_bypass_i)
    ,.stall_fence_i(stall_fence_i)
    ,.stall_remote_req_i(stall_remote_req_i)
    ,.id_rs1_i(id_rs1_i)
    ,.id_rs2_i(id_rs2_i)
    ,.id_rd_i(id_rd_i)
    ,.id_read_rs1_i(id_read_rs1_i)
    ,.id_read_rs2_i(id_read_rs2_i)
    ,.id_write_rd_i(id_write_rd_i)
    ,.dram_pend_i(dram_pend)
    ,.remote_pend_i(remote_pend)
    ,.idiv_pend_i(idiv_pend)
    ,.bubble_valid_o(bubble_valid)
    ,.bubble_kind_o(exe_bubble_type_o)
    ,.bubble_pc_o(exe_bubble_pc_o)
  );

  bubble_counter_bank cnt0 (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.bubble_valid_i(bubble_valid)
    ,.bubble_kind_i(exe_bubble_type_o)
    ,.clear_all_i(clear_all)
    ,.rd_idx_i(rd_idx)
    ,.rd_count_o(rd_count)
  );

  axil_prof_regs regs0 (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.araddr_i(araddr_i)
    ,.arvalid_i(arvalid_i)
    ,.arready_o(arready_o)
    ,.rdata_o(rdata_o)
    ,.rresp_o(rresp_o)
    ,.rvalid_o(rvalid_o)
    ,.rready_i(rready_i)
    ,.awaddr_i(awaddr_i)
    ,.awvalid_i(awvalid_i)
    ,.awready_o(awready_o)
    ,.wdata_i(wdata_i)
    ,.wvalid_i(wvalid_i)
    ,.wready_o(wready_o)
    ,.bresp_o(bresp_o)
    ,.bvalid_o(bvalid_o)
    ,.bready_i(bready_i)
    ,.rd_idx_o(rd_idx)
    ,.rd_count_i(rd_count)
    ,.clear_all_o(clear_all)
  );

endmodule

/* verilog/axil_prof_regs.sv */
module axil_prof_regs
  import bubble_prof_pkg::*;
  (
  input logic clk_i
  ,input logic reset_i

  ,input  axil_addr_t araddr_i
  ,input  logic       arvalid_i
  ,output logic       arready_o
  ,output axil_data_t rdata_o
  ,output logic [1:0] rresp_o
  ,output logic       rvalid_o
  ,input  logic       rready_i

  ,input  axil_addr_t awaddr_i
  ,input  logic       awvalid_i
  ,output logic       awready_o
  ,input  axil_data_t wdata_i
  ,input  logic       wvalid_i
  ,output logic       wready_o
  ,output logic [1:0] bresp_o
  ,output logic       bvalid_o
  ,input  logic       bready_i

  ,output logic [cause_width_lp-1:0] rd_idx_o
  ,input  count_t                    rd_count_i
  ,output logic                      clear_all_o
  );

  logic       rvalid_r;
  axil_data_t rdata_r;
  logic [1:0] rresp_r;
  logic       bvalid_r;
  logic       clear_r;
  logic       ar_fire;
  logic       aw_fire;

  assign arready_o = !rvalid_r; // One read in flight
  assign ar_fire   = arvalid_i && arready_o;
  assign rd_idx_o  = araddr_i[cause_width_lp+1:2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else if (ar_fire) begin
      rvalid_r <= 1'b1;
    end else if (rready_i) begin
      rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      rdata_r <= (araddr_i < cause_addr_end_lp) ? rd_count_i : '0;
      rresp_r <= (araddr_i < cause_addr_end_lp) ? resp_okay_lp : resp_slverr_lp;
    end
  end

  // AW and W taken only as a pair
  assign aw_fire   = awvalid_i && wvalid_i && !bvalid_r;
  assign awready_o = aw_fire;
  assign wready_o  = aw_fire;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
      clear_r  <= 1'b0;
    end else begin
      clear_r <= aw_fire && (awaddr_i == clear_addr_lp) && wdata_i[0];
      if (aw_fire) begin
        bvalid_r <= 1'b1;
      end else if (bready_i) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  assign rvalid_o    = rvalid_r;
  assign rdata_o     = rdata_r;
  assign rresp_o     = rresp_r;
  assign bvalid_o    = bvalid_r;
  assign bresp_o     = resp_okay_lp;
  assign clear_all_o = clear_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
    (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)));

endmodule

/* verilog/bubble_counter_bank.sv */
module bubble_counter_bank
  import bubble_prof_pkg::*;
  (
  input logic clk_i
  ,input logic reset_i

  ,input logic    bubble_valid_i
  ,input bubble_e bubble_kind_i
  ,input logic    clear_all_i

  ,input  logic [cause_width_lp-1:0] rd_idx_i
  ,output count_t                    rd_count_o
  );

  // Slot 0 counts useful cycles, the rest count bubbles per cause
  count_t count_r [num_causes_lp];
  logic   inc_ok;

  assign inc_ok = bubble_valid_i && (count_r[bubble_kind_i] != '1); // Saturate

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_all_i) begin
      for (int i = 0; i < num_causes_lp; i++) begin
        count_r[i] <= '0;
      end
    end else if (inc_ok) begin
      count_r[bubble_kind_i] <= count_r[bubble_kind_i] + 1'b1;
    end
  end

  always_comb begin
    rd_count_o = '0;
    if (rd_idx_i < num_causes_lp) begin
      rd_count_o = count_r[rd_idx_i];
    end
  end

endmodule

/* classifier/exe_bubble_classifier.sv */
module exe_bubble_classifier
  import bubble_prof_pkg::*;
  (
  input logic clk_i
  ,input logic reset_i

  ,input pc_t if_pc_i
  ,input pc_t id_pc_i
  ,input pc_t exe_pc_i

  ,input logic stall_all_i
  ,input logic icache_miss_i
  ,input logic icache_miss_in_pipe_i
  ,input logic branch_mispredict_i
  ,input logic jalr_mispredict_i

  ,input logic stall_depend_long_op_i
  ,input logic stall_bypass_i
  ,input logic stall_fence_i
  ,input logic stall_remote_req_i

  ,input reg_id_t id_rs1_i
  ,input reg_id_t id_rs2_i
  ,input reg_id_t id_rd_i
  ,input logic    id_read_rs1_i
  ,input logic    id_read_rs2_i
  ,input logic    id_write_rd_i

  ,input logic [int_regs_lp-1:0] dram_pend_i
  ,input logic [int_regs_lp-1:0] remote_pend_i
  ,input logic [int_regs_lp-1:0] idiv_pend_i

  ,output logic    bubble_valid_o
  ,output bubble_e bubble_kind_o
  ,output pc_t     bubble_pc_o
  );

  typedef enum logic [1:0] {
    id_no_bubble,
    id_branch_miss,
    id_jalr_miss,
    id_icache_miss
  } id_bubble_e;

  pc_t        icache_miss_pc_r;
  id_bubble_e id_bubble_r;
  pc_t        id_bubble_pc_r;
  logic       bubble_valid_r;
  bubble_e    exe_kind_r;
  pc_t        exe_pc_r;
  logic       dep_dram;
  logic       dep_remote;
  logic       dep_idiv;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      icache_miss_pc_r <= '0;
    end else if (icache_miss_i) begin
      icache_miss_pc_r <= if_pc_i;
    end
  end

  // Bubble sitting in ID, shows up in EXE one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_bubble_r    <= id_no_bubble;
      id_bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      if (branch_mispredict_i) begin
        id_bubble_r    <= id_branch_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (jalr_mispredict_i) begin
        id_bubble_r    <= id_jalr_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (icache_miss_in_pipe_i) begin
        id_bubble_r    <= id_icache_miss;
        id_bubble_pc_r <= icache_miss_pc_r;
      end else begin
        id_bubble_r    <= id_no_bubble;
        id_bubble_pc_r <= '0;
      end
    end
  end

  // Operands of the ID instruction waiting on a long op
  assign dep_dram = stall_depend_long_op_i
    & ((id_read_rs1_i & dram_pend_i[id_rs1_i]) | (id_read_rs2_i & dram_pend_i[id_rs2_i])
       | (id_write_rd_i & dram_pend_i[id_rd_i]));
  assign dep_remote = stall_depend_long_op_i
    & ((id_read_rs1_i & remote_pend_i[id_rs1_i]) | (id_read_rs2_i & remote_pend_i[id_rs2_i])
       | (id_write_rd_i & remote_pend_i[id_rd_i]));
  assign dep_idiv = stall_depend_long_op_i
    & ((id_read_rs1_i & idiv_pend_i[id_rs1_i]) | (id_read_rs2_i & idiv_pend_i[id_rs2_i])
       | (id_write_rd_i & idiv_pend_i[id_rd_i]));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bubble_valid_r <= 1'b0;
      exe_kind_r     <= no_bubble;
      exe_pc_r       <= '0;
    end else begin
      bubble_valid_r <= !stall_all_i;
      if (!stall_all_i) begin
        if (branch_mispredict_i || jalr_mispredict_i) begin
          exe_kind_r <= branch_mispredict_i ? branch_miss : jalr_miss;
          exe_pc_r   <= exe_pc_i;
        end else if (id_bubble_r != id_no_bubble) begin
          exe_kind_r <= (id_bubble_r == id_branch_miss) ? branch_miss :
                        (id_bubble_r == id_jalr_miss)   ? jalr_miss : icache_miss;
          exe_pc_r   <= id_bubble_pc_r;
        end else if (dep_dram || dep_remote || dep_idiv) begin
          exe_kind_r <= dep_dram ? depend_dram : dep_remote ? depend_remote : depend_idiv;
          exe_pc_r   <= id_pc_i;
        end else if (stall_bypass_i || stall_fence_i || stall_remote_req_i) begin
          exe_kind_r <= stall_bypass_i ? bypass : stall_fence_i ? fence : remote_req;
          exe_pc_r   <= id_pc_i;
        end else begin
          exe_kind_r <= no_bubble;
          exe_pc_r   <= '0;
        end
      end
    end
  end

  assign bubble_valid_o = bubble_valid_r;
  assign bubble_kind_o  = exe_kind_r;
  assign bubble_pc_o    = exe_pc_r;

  // Core resolves one kind of control transfer per cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(branch_mispredict_i && jalr_mispredict_i));

endmodule

/* classifier/long_op_scoreboard.sv */
module long_op_scoreboard
  import bubble_prof_pkg::*;
  (
  input logic clk_i
  ,input logic reset_i

  ,sb_update_if.sink upd

  ,output logic [int_regs_lp-1:0] dram_pend_o
  ,output logic [int_regs_lp-1:0] remote_pend_o
  ,output logic [int_regs_lp-1:0] idiv_pend_o
  );

  logic [int_regs_lp-1:0] dram_r;
  logic [int_regs_lp-1:0] remote_r;
  logic [int_regs_lp-1:0] idiv_r;
  logic [int_regs_lp-1:0] set_mask;
  logic [int_regs_lp-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (upd.set_valid && upd.set_rd != '0) begin // x0 never waits
      set_mask[upd.set_rd] = 1'b1;
    end
    if (upd.clr_valid) begin
      clr_mask[upd.clr_rd] = 1'b1;
    end
  end

  // Set applied after clear, so set wins on the same register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dram_r   <= '0;
      remote_r <= '0;
      idiv_r   <= '0;
    end else begin
      dram_r   <= (dram_r & ~clr_mask) | ((upd.set_kind == dram_load) ? set_mask : '0);
      remote_r <= (remote_r & ~clr_mask) | ((upd.set_kind == remote_load) ? set_mask : '0);
      idiv_r   <= (idiv_r & ~clr_mask) | ((upd.set_kind == idiv) ? set_mask : '0);
    end
  end

  assign dram_pend_o   = dram_r;
  assign remote_pend_o = remote_r;
  assign idiv_pend_o   = idiv_r;

  // Writeback only for a register that some long op still owns
  assert property (@(posedge clk_i) disable iff (reset_i)
    upd.clr_valid |-> ((dram_r[upd.clr_rd] | remote_r[upd.clr_rd] | idiv_r[upd.clr_rd])
                       || (upd.set_valid && upd.set_rd == upd.clr_rd)));

endmodule

/* common/sb_update_if.sv */
interface sb_update_if
  import bubble_prof_pkg::*;
  ();

  logic     set_valid; // Long op issued
  reg_id_t  set_rd;
  long_op_e set_kind;
  logic     clr_valid; // Writeback
  reg_id_t  clr_rd;

  modport src (
    output set_valid
    ,output set_rd
    ,output set_kind
    ,output clr_valid
    ,output clr_rd
  );

  modport sink (
    input set_valid
    ,input set_rd
    ,input set_kind
    ,input clr_valid
    ,input clr_rd
  );

endinterface

/* common/bubble_prof_pkg.sv */
package bubble_prof_pkg;

  localparam int pc_width_lp        = 32;
  localparam int reg_id_width_lp    = 5;
  localparam int int_regs_lp        = 32;
  localparam int count_width_lp     = 32;
  localparam int axil_addr_width_lp = 8;
  localparam int axil_data_width_lp = 32;
  localparam int cause_width_lp     = 4;

  typedef logic [pc_width_lp-1:0]        pc_t;
  typedef logic [reg_id_width_lp-1:0]    reg_id_t;
  typedef logic [count_width_lp-1:0]     count_t;
  typedef logic [axil_addr_width_lp-1:0] axil_addr_t;
  typedef logic [axil_data_width_lp-1:0] axil_data_t;

  // EXE bubble causes, also the counter index
  typedef enum logic [cause_width_lp-1:0] {
    no_bubble     = 4'd0,
    branch_miss   = 4'd1,
    jalr_miss     = 4'd2,
    icache_miss   = 4'd3,
    depend_dram   = 4'd4,
    depend_remote = 4'd5,
    depend_idiv   = 4'd6,
    bypass        = 4'd7,
    fence         = 4'd8,
    remote_req    = 4'd9
  } bubble_e;

  typedef enum logic [1:0] {
    dram_load,
    remote_load, // Group or global
    idiv
  } long_op_e;

  localparam int num_causes_lp = 10;

  // Register map
  localparam axil_addr_t clear_addr_lp     = 8'h40;
  localparam axil_addr_t cause_addr_end_lp = axil_addr_t'(num_causes_lp * 4);

  localparam logic [1:0] resp_okay_lp   = 2'b00;
  localparam logic [1:0] resp_slverr_lp = 2'b10;

endpackage
